//--- verilog/rvCorePkg.sv
// Shared constants of the RV32I core, referenced by scoped name from every RTL file
`default_nettype none

package rvCorePkg;

	// ------------------------------
	// Data and address width
	// ------------------------------
	localparam int xlen = 32;

	// ------------------------------
	// Major opcodes, instr[6:0]
	// ------------------------------
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;

	// ------------------------------
	// ALUOp codes from the decoder
	// ------------------------------
	localparam logic [3:0] aluR      = 4'b0000; // funct3 + funct7
	localparam logic [3:0] aluImm    = 4'b1100; // funct3, bit 30 for shifts
	localparam logic [3:0] aluLoad   = 4'b1110; // address add
	localparam logic [3:0] aluStore  = 4'b0001; // address add
	localparam logic [3:0] aluBranch = 4'b1111; // compare
	localparam logic [3:0] aluLui    = 4'b0011; // pass B
	localparam logic [3:0] aluAuipc  = 4'b0111; // PC + imm

	// Operand A source, the AuipcLui field
	localparam logic [1:0] srcPc   = 2'b00;
	localparam logic [1:0] srcZero = 2'b01;
	localparam logic [1:0] srcRs1  = 2'b10;

endpackage

`default_nettype wire

//--- verilog/mainControl.sv
// Main control decoder, opcode to datapath controls, squashed to a bubble on hazard
`timescale 1ns/1ns
`default_nettype none

module mainControl (
	input  wire logic       clk,         // assertion sampling only
	input  wire logic       arstN,
	input  wire logic [6:0] instruction, // opcode field
	input  wire logic       hazard,      // squash current instruction
	output logic            Branch,
	output logic            MemRead,
	output logic            MemtoReg,
	output logic            MemWrite,
	output logic            RegWrite,
	output logic            ALUSrc,
	output logic [3:0]      ALUOp,
	output logic [1:0]      AuipcLui
);

	always_comb begin
		// Bubble values, also used for unknown opcodes
		Branch   = 1'b0;
		MemRead  = 1'b0;
		MemtoReg = 1'b0;
		MemWrite = 1'b0;
		RegWrite = 1'b0;
		ALUSrc   = 1'b0;
		ALUOp    = rvCorePkg::aluR;
		AuipcLui = rvCorePkg::srcPc;
		if (!hazard) begin
			case (instruction)
				rvCorePkg::opR: begin
					RegWrite = 1'b1;
					ALUOp    = rvCorePkg::aluR;
					AuipcLui = rvCorePkg::srcRs1;
				end
				rvCorePkg::opImm: begin
					RegWrite = 1'b1;
					ALUSrc   = 1'b1;
					ALUOp    = rvCorePkg::aluImm;
					AuipcLui = rvCorePkg::srcRs1;
				end
				rvCorePkg::opLoad: begin
					MemRead  = 1'b1; // loads only
					MemtoReg = 1'b1; // loads only
					RegWrite = 1'b1;
					ALUSrc   = 1'b1;
					ALUOp    = rvCorePkg::aluLoad;
					AuipcLui = rvCorePkg::srcRs1;
				end
				rvCorePkg::opStore: begin
					MemWrite = 1'b1;
					ALUSrc   = 1'b1;
					ALUOp    = rvCorePkg::aluStore;
					AuipcLui = rvCorePkg::srcRs1;
				end
				rvCorePkg::opBranch: begin
					Branch   = 1'b1;
					ALUOp    = rvCorePkg::aluBranch; // rs1 vs rs2
					AuipcLui = rvCorePkg::srcRs1;
				end
				rvCorePkg::opLui: begin
					RegWrite = 1'b1;
					ALUSrc   = 1'b1;
					ALUOp    = rvCorePkg::aluLui;
					AuipcLui = rvCorePkg::srcZero;
				end
				rvCorePkg::opAuipc: begin
					RegWrite = 1'b1;
					ALUSrc   = 1'b1;
					ALUOp    = rvCorePkg::aluAuipc;
					AuipcLui = rvCorePkg::srcPc; // PC-relative
				end
				default: ; // stays a bubble
			endcase
		end
	end

	// Controls must resolve even for a squashed or unloaded fetch word
	ctrlKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown({Branch, MemRead, MemtoReg, MemWrite, RegWrite, ALUSrc, ALUOp, AuipcLui}));

endmodule

`default_nettype wire

//--- verilog/immGen.sv
// Immediate generator, picks the I, S, B or U field by opcode and sign-extends it
`timescale 1ns/1ns
`default_nettype none

module immGen (
	input  wire logic [31:0]                 instr,
	output logic      [rvCorePkg::xlen-1:0] imm
);

	always_comb begin
		case (instr[6:0])
			rvCorePkg::opImm,
			rvCorePkg::opLoad:
				imm = {{20{instr[31]}}, instr[31:20]}; // I
			rvCorePkg::opStore:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S
			rvCorePkg::opBranch:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0}; // B, byte offset
			rvCorePkg::opLui,
			rvCorePkg::opAuipc:
				imm = {instr[31:12], 12'b0}; // U
			default:
				imm = '0; // R-type and bubbles
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
// Integer ALU of the execute stage, with branch condition evaluation
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire logic                       clk,   // assertion sampling only
	input  wire logic                       arstN,
	input  wire logic [3:0]                 aluOp,
	input  wire logic [2:0]                 funct3,
	input  wire logic                       funct7b5, // instr[30]
	input  wire logic [rvCorePkg::xlen-1:0] a,
	input  wire logic [rvCorePkg::xlen-1:0] b,
	output logic      [rvCorePkg::xlen-1:0] result,
	output logic                            branchFlag
);

	logic [4:0] shamt;
	logic       altOp; // sub or sra selected

	assign shamt = b[4:0];
	// Bit 30 means sub only for R-type, for immediates only on shifts
	assign altOp = funct7b5 && (aluOp == rvCorePkg::aluR || funct3 == 3'b101);

	always_comb begin
		case (aluOp)
			rvCorePkg::aluR,
			rvCorePkg::aluImm: begin
				case (funct3)
					3'b000:  result = altOp ? a - b : a + b;
					3'b001:  result = a << shamt;
					3'b010:  result = {31'b0, $signed(a) < $signed(b)};
					3'b011:  result = {31'b0, a < b};
					3'b100:  result = a ^ b;
					3'b101:  result = altOp ? $unsigned($signed(a) >>> shamt) : a >> shamt;
					3'b110:  result = a | b;
					default: result = a & b;
				endcase
			end
			rvCorePkg::aluLui:    result = b;
			rvCorePkg::aluBranch: result = a - b; // not written back
			default:              result = a + b; // load, store, auipc
		endcase
	end

	// Condition only matters for aluBranch
	always_comb begin
		case (funct3)
			3'b000:  branchFlag = (a == b);                   // beq
			3'b001:  branchFlag = (a != b);                   // bne
			3'b100:  branchFlag = ($signed(a) < $signed(b));  // blt
			3'b101:  branchFlag = ($signed(a) >= $signed(b)); // bge
			3'b110:  branchFlag = (a < b);                    // bltu
			3'b111:  branchFlag = (a >= b);                   // bgeu
			default: branchFlag = 1'b0;
		endcase
	end

	// Decoder drives a defined op once the fetch register is out of reset
	aluOpKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(aluOp));

endmodule

`default_nettype wire

//--- verilog/regFile.sv
// Integer register file with two combinational reads and one clocked write, where x0 stays zero
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  wire logic                       clk,
	input  wire logic                       arstN,
	input  wire logic [4:0]                 rs1Addr,
	input  wire logic [4:0]                 rs2Addr,
	input  wire logic                       we,
	input  wire logic [4:0]                 rdAddr,
	input  wire logic [rvCorePkg::xlen-1:0] rdData,
	output logic      [rvCorePkg::xlen-1:0] rs1Data,
	output logic      [rvCorePkg::xlen-1:0] rs2Data
);

	logic [rvCorePkg::xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rdAddr != 5'd0) begin // x0 is read-only
			regs[rdAddr] <= rdData;
		end
	end

	// Slot 0 keeps its reset value, so reads of x0 give zero
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	x0Zero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0);

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
// Hazard sequencing, one stall cycle per load and one squash cycle after a taken branch
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input  wire logic clk,
	input  wire logic arstN,
	input  wire logic run,
	input  wire logic memRead,     // load in execute
	input  wire logic branchTaken,
	output logic      stall,       // hold PC and fetch register
	output logic      squash       // bubble the wrong-path fetch
);

	logic loadPending; // second cycle of a load
	logic squashQ;

	// First load cycle only, data memory answers in the next one
	assign stall  = run & memRead & ~loadPending;
	assign squash = squashQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			loadPending <= 1'b0;
			squashQ     <= 1'b0;
		end else begin
			loadPending <= stall;             // set for exactly one cycle
			squashQ     <= run & branchTaken;
		end
	end

	// A squashed instruction never reads memory, so these cannot overlap
	noStallSquash: assert property (@(posedge clk) disable iff (!arstN) !(stall && squash));

endmodule

`default_nettype wire

//--- verilog/dataMem.sv
// Word-addressed data memory, synchronous read and clocked write
`timescale 1ns/1ns
`default_nettype none

module dataMem #(
	parameter int dataDepth = 64
) (
	input  wire logic                       clk,
	input  wire logic                       re,
	input  wire logic                       we,
	input  wire logic [rvCorePkg::xlen-3:0] addr, // word address
	input  wire logic [rvCorePkg::xlen-1:0] wdata,
	output logic      [rvCorePkg::xlen-1:0] rdata
);

	localparam int aw = $clog2(dataDepth);

	logic [rvCorePkg::xlen-1:0] mem [dataDepth];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr[aw-1:0]] <= wdata;
		if (re)
			rdata <= mem[addr[aw-1:0]]; // valid next cycle
	end

	// Program must keep its data inside the array, no wrap-around
	inRange: assert property (@(posedge clk) (re || we) |-> (addr < dataDepth));

endmodule

`default_nettype wire

//--- verilog/riscvCore.sv
// Two-stage RV32I core top level, fetch plus execute, with program load and event ports
`timescale 1ns/1ns
`default_nettype none

module riscvCore #(
	parameter int progDepth = 64, // instruction words
	parameter int dataDepth = 64  // data words
) (
	input  wire logic                         clk,
	input  wire logic                         arstN,
	input  wire logic                         run,
	input  wire logic                         progWrite, // only while run is low
	input  wire logic [$clog2(progDepth)-1:0] progAddr,  // word index
	input  wire logic [rvCorePkg::xlen-1:0]   progData,
	output logic                              wbValid,
	output logic      [4:0]                   wbAddr,
	output logic      [rvCorePkg::xlen-1:0]   wbData,
	output logic                              storeValid,
	output logic      [rvCorePkg::xlen-1:0]   storeAddr, // byte address
	output logic      [rvCorePkg::xlen-1:0]   storeData
);

	localparam int progAw = $clog2(progDepth);
	localparam logic [31:0] bubble = 32'h0000_0000; // opcode 0 decodes inactive

	logic [rvCorePkg::xlen-1:0] pc;
	logic [rvCorePkg::xlen-1:0] fetchPc; // PC of the instruction in execute
	logic [31:0]                fetchReg;
	logic [31:0]                progMem [progDepth];

	logic       Branch, MemRead, MemtoReg, MemWrite, RegWrite, ALUSrc;
	logic [3:0] ALUOp;
	logic [1:0] AuipcLui;
	logic       stall, squash, branchTaken, branchFlag, regWe;

	logic [rvCorePkg::xlen-1:0] imm, rs1Data, rs2Data, opA, opB;
	logic [rvCorePkg::xlen-1:0] aluResult, memRdata, branchTarget;

	// ------------------------------
	// Fetch
	// ------------------------------
	always_ff @(posedge clk) begin
		if (progWrite)
			progMem[progAddr] <= progData;
	end

	assign branchTarget = fetchPc + imm;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc       <= '0;
			fetchPc  <= '0;
			fetchReg <= bubble;
		end else if (!run) begin // held idle during program load
			pc       <= '0;
			fetchPc  <= '0;
			fetchReg <= bubble;
		end else if (!stall) begin
			pc       <= branchTaken ? branchTarget : pc + 32'd4;
			fetchPc  <= pc;
			fetchReg <= progMem[pc[progAw+1:2]]; // registered store output
		end
	end

	// ------------------------------
	// Execute
	// ------------------------------
	mainControl i_mainControl (
		.clk(clk), .arstN(arstN), .instruction(fetchReg[6:0]), .hazard(squash),
		.Branch(Branch), .MemRead(MemRead), .MemtoReg(MemtoReg), .MemWrite(MemWrite),
		.RegWrite(RegWrite), .ALUSrc(ALUSrc), .ALUOp(ALUOp), .AuipcLui(AuipcLui)
	);

	immGen i_immGen (.instr(fetchReg), .imm(imm));

	regFile i_regFile (
		.clk(clk), .arstN(arstN), .rs1Addr(fetchReg[19:15]), .rs2Addr(fetchReg[24:20]),
		.we(regWe), .rdAddr(fetchReg[11:7]), .rdData(wbData),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	always_comb begin
		case (AuipcLui)
			rvCorePkg::srcPc:   opA = fetchPc;
			rvCorePkg::srcZero: opA = '0;
			default:            opA = rs1Data;
		endcase
	end
	assign opB = ALUSrc ? imm : rs2Data;

	alu i_alu (
		.clk(clk), .arstN(arstN), .aluOp(ALUOp), .funct3(fetchReg[14:12]),
		.funct7b5(fetchReg[30]), .a(opA), .b(opB), .result(aluResult), .branchFlag(branchFlag)
	);

	assign branchTaken = Branch & branchFlag;

	hazardUnit i_hazardUnit (
		.clk(clk), .arstN(arstN), .run(run), .memRead(MemRead),
		.branchTaken(branchTaken), .stall(stall), .squash(squash)
	);

	dataMem #(.dataDepth(dataDepth)) i_dataMem (
		.clk(clk), .re(MemRead), .we(MemWrite), .addr(aluResult[rvCorePkg::xlen-1:2]),
		.wdata(rs2Data), .rdata(memRdata)
	);

	// ------------------------------
	// Writeback and events
	// ------------------------------
	assign regWe      = RegWrite & ~stall; // load writes in its second cycle
	assign wbData     = MemtoReg ? memRdata : aluResult;
	assign wbAddr     = fetchReg[11:7];
	assign wbValid    = regWe && (wbAddr != 5'd0);
	assign storeValid = MemWrite; // stores never stall
	assign storeAddr  = aluResult;
	assign storeData  = rs2Data;

endmodule

`default_nettype wire

//--- testbench/tbRiscvCore.sv
// Testbench for the two-stage RV32I core, loads the golden program and checks the event order
`timescale 1ns/1ns
`default_nettype none

module tbRiscvCore;

	localparam int progDepth     = 64;
	localparam int dataDepth     = 64;
	localparam int imageWords    = 256;  // golden image size
	localparam int eventBase     = 64;   // event triplets start at @40
	localparam int timeoutCycles = 2000;
	localparam int quietCycles   = 50;   // branch-to-self must stay silent

	logic                         clk = 1'b0;
	logic                         arstN;
	logic                         run;
	logic                         progWrite;
	logic [$clog2(progDepth)-1:0] progAddr;
	logic [31:0]                  progData;
	logic                         wbValid;
	logic [4:0]                   wbAddr;
	logic [31:0]                  wbData;
	logic                         storeValid;
	logic [31:0]                  storeAddr;
	logic [31:0]                  storeData;

	logic [31:0] golden [imageWords]; // program words, then kind/addr/data triplets
	int          eventCount;

	always #2 clk = ~clk; // 4 ns period

	riscvCore #(
		.progDepth(progDepth),
		.dataDepth(dataDepth)
	) i_riscvCore (
		.clk(clk), .arstN(arstN), .run(run),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
	);

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// Kind 1 is a register write, kind 2 a store
	function automatic string describeEvent(input logic [31:0] kind, input logic [31:0] addr,
		input logic [31:0] data);
		if (kind == 32'd1)
			return $sformatf("register write x%0d = %h", addr, data);
		return $sformatf("store of %h to address %h", data, addr);
	endfunction

	function automatic string describeSeen();
		if (wbValid)
			return describeEvent(32'd1, {27'b0, wbAddr}, wbData);
		return describeEvent(32'd2, storeAddr, storeData);
	endfunction

	// Waits for the next strobe, then compares it with golden entry idx
	task automatic expectEvent(input int idx);
		logic [31:0] kind;
		logic [31:0] addr;
		logic [31:0] data;
		int          cycles;
		bit          seen;
		bit          match;
		kind   = golden[eventBase + 3*idx];
		addr   = golden[eventBase + 3*idx + 1];
		data   = golden[eventBase + 3*idx + 2];
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < timeoutCycles) begin
			@(negedge clk); // outputs settled since the rising edge
			cycles++;
			seen = wbValid || storeValid;
		end
		assert (seen) else
			failRun($sformatf("Timeout: expected %s (event %0d) never arrived within %0d cycles",
				describeEvent(kind, addr, data), idx, timeoutCycles));
		if (kind == 32'd1)
			match = wbValid && wbAddr == addr[4:0] && wbData == data;
		else
			match = storeValid && storeAddr == addr && storeData == data;
		assert (match) else
			failRun($sformatf("Mismatch at %0t: event %0d expected %s, got %s",
				$time, idx, describeEvent(kind, addr, data), describeSeen()));
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		arstN     = 1'b0;
		run       = 1'b0;
		progWrite = 1'b0;
		progAddr  = '0;
		progData  = '0;
		for (int i = 0; i < imageWords; i++)
			golden[i] = '0; // kind 0 ends the event list
		$readmemh("testbench/golden_riscvCore.txt", golden);
		eventCount = 0;
		while (eventBase + 3*(eventCount + 1) <= imageWords
			&& golden[eventBase + 3*eventCount] != 32'd0)
			eventCount++;
		assert (eventCount > 0) else
			failRun("The golden file holds no expected events");

		repeat (10) @(posedge clk); // reset for 10 cycles
		#1 arstN = 1'b1;

		// Program load while run is low
		for (int i = 0; i < progDepth; i++) begin
			@(posedge clk);
			#1;
			progWrite = 1'b1;
			progAddr  = i[$clog2(progDepth)-1:0];
			progData  = golden[i];
		end
		@(posedge clk);
		#1;
		progWrite = 1'b0;
		run       = 1'b1;

		for (int e = 0; e < eventCount; e++)
			expectEvent(e);

		// Core now spins on its final branch
		for (int c = 0; c < quietCycles; c++) begin
			@(negedge clk);
			assert (!wbValid && !storeValid) else
				failRun($sformatf("Mismatch at %0t: unexpected %s after the last expected event",
					$time, describeSeen()));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/golden_riscvCore.txt
// Program words from @00, four per line, word index rising left to right
// Events from @40, one per line: kind (1 register write, 2 store), rd or byte address, data
@00
FFB00093 00300113 002081B3 40110233 // x1=-5, x2=3, add, sub
4020D2B3 0020D333 0020A3B3 0020B433 // sra, srl, slt, sltu
123454B7 00001517 004126A3 01002583 // lui, auipc, sw 13(x2), lw 16(x0)
00158613 00700013 002006B3 00409713 // use of load, write x0, read x0, slli
4010D793 00210463 00100F93 00209463 // srai, beq taken, planted x31, bne taken
00100F93 0020C463 00100F93 00115463 // planted, blt taken, planted, bge taken
00100F93 00116463 00100F93 0020F463 // planted, bltu taken, planted, bgeu taken
00100F93 00208463 02A00813 00000063 // planted, beq not taken, addi x16, branch to self
@40
1 1 FFFFFFFB
1 2 00000003
1 3 FFFFFFFE
1 4 00000008
1 5 FFFFFFFF
1 6 1FFFFFFF
1 7 00000001
1 8 00000000
1 9 12345000
1 A 00001024
2 10 00000008
1 B 00000008
1 C 00000009
1 D 00000003
1 E FFFFFFB0
1 F FFFFFFFD
1 10 0000002A

//--- vlog.f
verilog/rvCorePkg.sv
verilog/mainControl.sv
verilog/immGen.sv
verilog/alu.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/dataMem.sv
verilog/riscvCore.sv
testbench/tbRiscvCore.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbRiscvCore
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
